// ==== Makefile ====
SRCS := $(filter-out +incdir+%,$(shell cat list.f)) tb_wired_rob_tasks.svh

.PHONY: all run clean

all: run

obj_dir/Vtb_wired_rob: list.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_wired_rob -f list.f

run: obj_dir/Vtb_wired_rob
	./obj_dir/Vtb_wired_rob | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== list.f ====
+incdir+.
wired_pkg.sv
wired_rob_if.sv
wired_registers_file_banked.sv
wired_rob.sv
wired_rob_dispatch.sv
wired_rob_commit.sv
wired_rob_top.sv
tb_wired_rob.sv

// ==== tb_wired_rob_tasks.svh ====
// reference model with one slot per ROB id and the program order queue
rid_t      model_q[$];
rid_t      tail_m;
logic      done_m   [DEPTH];
word_t     pc_m     [DEPTH];
arch_rid_t wreg_m   [DEPTH];
logic      we_m     [DEPTH];
word_t     data_m   [DEPTH];
excp_t     excp_m   [DEPTH];
logic      jump_m   [DEPTH];
word_t     target_m [DEPTH];
int        commit_count;
int        flush_count;
int        dual_count;
word_t     next_pc;

task automatic compare_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
  assert (got === exp) else begin
    errors++;
    $display("MISMATCH at time %0d ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
  end
endtask

task automatic expect_true(input logic cond, input string what);
  assert (cond) else begin
    errors++;
    $display("ERROR at time %0d ns: %s", $time, what);
  end
endtask

task automatic clear_inputs();
  dispatch_valid = '0;
  dispatch_wreg  = '0;
  dispatch_we    = '0;
  dispatch_pc    = '0;
  src_rob_id     = '0;
  cdb_valid      = '0;
  cdb_wid        = '0;
  cdb_wdata      = '0;
  cdb_excp       = '0;
  cdb_need_jump  = '0;
  cdb_target     = '0;
endtask

// checks the DUT at each edge and then moves the model on
task automatic observe_edge();
  logic [1:0] exp_ret;
  logic       exp_flush;
  logic       excp_hit;
  logic       room;
  rid_t       id;
  exp_ret   = 2'b00;
  exp_flush = 1'b0;
  excp_hit  = 1'b0;
  room      = (model_q.size() <= DEPTH - 2);
  if (model_q.size() > 0 && done_m[model_q[0]]) begin
    exp_ret[0] = 1'b1;
    excp_hit   = (excp_m[model_q[0]] != 2'b00);
    exp_flush  = excp_hit || jump_m[model_q[0]];
  end
  if (exp_ret[0] && !exp_flush && model_q.size() > 1 && done_m[model_q[1]]) begin
    exp_ret[1] = 1'b1;
  end
  compare_value("commit_valid_o", commit_valid, exp_ret);
  compare_value("flush_o", flush, exp_flush);
  compare_value("commit_excp_o", commit_excp, excp_hit);
  compare_value("dispatch_ready_o", dispatch_ready, room);
  for (int k = 0; k < 2; k++) begin
    if (exp_ret[k]) begin
      id = model_q[k];
      compare_value($sformatf("commit_pc_o[%0d]", k), commit_pc[k], pc_m[id]);
      compare_value($sformatf("commit_wreg_o[%0d]", k), commit_wreg[k],
                    we_m[id] ? wreg_m[id] : 5'd0);
      compare_value($sformatf("commit_wdata_o[%0d]", k), commit_wdata[k],
                    we_m[id] ? data_m[id] : 32'd0);
    end
  end
  if (exp_flush) begin
    compare_value("redirect_pc_o", redirect_pc, excp_hit ? EXCP_VECTOR : target_m[model_q[0]]);
  end
  for (int k = 0; k < 2; k++) begin
    if (dispatch_valid[k] && room) begin
      compare_value($sformatf("dispatch_rob_id_o[%0d]", k), dispatch_rob_id[k], tail_m);
      pc_m[tail_m]   = dispatch_pc[k];
      wreg_m[tail_m] = dispatch_wreg[k];
      we_m[tail_m]   = dispatch_we[k];
      done_m[tail_m] = 1'b0;
      model_q.push_back(tail_m);
      tail_m = tail_m + 1'b1;
    end
  end
  for (int k = 0; k < 2; k++) begin
    if (cdb_valid[k]) begin
      id           = cdb_wid[k];
      done_m[id]   = 1'b1;
      data_m[id]   = cdb_wdata[k];
      excp_m[id]   = cdb_excp[k];
      jump_m[id]   = cdb_need_jump[k];
      target_m[id] = cdb_target[k];
    end
  end
  if (exp_flush) begin
    model_q.delete();
    tail_m = '0;
  end else begin
    for (int k = 0; k < 2; k++) begin
      if (exp_ret[k]) begin
        void'(model_q.pop_front());
      end
    end
  end
  // tallies count what the DUT did
  for (int k = 0; k < 2; k++) begin
    if (commit_valid[k] === 1'b1) begin
      commit_count++;
    end
  end
  if (flush === 1'b1) begin
    flush_count++;
  end
  if (commit_valid === 2'b11) begin
    dual_count++;
  end
endtask

// pc picks the destination and x0 means no register write
task automatic load_lane(input int k);
  dispatch_pc[k]   = next_pc;
  dispatch_wreg[k] = next_pc[6:2];
  dispatch_we[k]   = (next_pc[6:2] != 5'd0);
  next_pc          = next_pc + 32'd4;
endtask

task automatic wait_room();
  int n;
  n = 0;
  @(negedge clk);
  while (model_q.size() > DEPTH - 2 && n < 100) begin
    @(negedge clk);
    n++;
  end
  expect_true(n < 100, "no room in the ROB for a dispatch");
endtask

task automatic dispatch_one(output rid_t id0);
  wait_room();
  id0 = tail_m;
  load_lane(0);
  dispatch_valid = 2'b01;
  @(negedge clk);
  dispatch_valid = 2'b00;
endtask

task automatic dispatch_two(output rid_t id0, output rid_t id1);
  wait_room();
  id0 = tail_m;
  id1 = tail_m + 1'b1;
  load_lane(0);
  load_lane(1);
  dispatch_valid = 2'b11;
  @(negedge clk);
  dispatch_valid = 2'b00;
endtask

task automatic complete(input rid_t id, input word_t data, input excp_t excp,
                        input logic jump, input word_t target);
  @(negedge clk);
  cdb_valid        = 2'b01;
  cdb_wid[0]       = id;
  cdb_wdata[0]     = data;
  cdb_excp[0]      = excp;
  cdb_need_jump[0] = jump;
  cdb_target[0]    = target;
  @(negedge clk);
  cdb_valid = 2'b00;
endtask

task automatic complete_two(input rid_t id0, input word_t data0,
                            input rid_t id1, input word_t data1);
  @(negedge clk);
  cdb_valid     = 2'b11;
  cdb_wid       = {id1, id0};
  cdb_wdata     = {data1, data0};
  cdb_excp      = '0;
  cdb_need_jump = '0;
  @(negedge clk);
  cdb_valid = 2'b00;
endtask

task automatic wait_commits(input int target);
  int n;
  n = 0;
  while (commit_count < target && n < 100) begin
    @(negedge clk);
    n++;
  end
  expect_true(commit_count >= target, "timed out waiting for commits");
endtask

task automatic wait_flushes(input int target);
  int n;
  n = 0;
  while (flush_count < target && n < 100) begin
    @(negedge clk);
    n++;
  end
  expect_true(flush_count >= target, "timed out waiting for a flush");
endtask

task automatic wait_empty();
  int n;
  n = 0;
  while (model_q.size() != 0 && n < 100) begin
    @(negedge clk);
    n++;
  end
  expect_true(model_q.size() == 0, "timed out waiting for the ROB to drain");
endtask

// complete whatever is still pending in program order
task automatic drain_rob();
  rid_t ids[$];
  ids = model_q;
  foreach (ids[i]) begin
    if (!done_m[ids[i]]) begin
      complete(ids[i], 32'h5a5a_0000 | {28'd0, ids[i]}, 2'b00, 1'b0, 32'd0);
    end
  end
  wait_empty();
endtask

task automatic after_reset();
  @(posedge clk);
  compare_value("dispatch_ready_o", dispatch_ready, 1'b1);
  compare_value("commit_valid_o", commit_valid, 2'b00);
  compare_value("flush_o", flush, 1'b0);
endtask

task automatic forwarding_readiness();
  rid_t older;
  rid_t younger;
  dispatch_two(older, younger);
  src_rob_id[0] = older;
  src_rob_id[1] = younger;
  repeat (2) begin
    @(posedge clk);
    compare_value("operand_ready_o[0]", operand_ready[0], 1'b0);
    compare_value("operand_ready_o[1]", operand_ready[1], 1'b0);
  end
  complete(younger, 32'hcafe_0001, 2'b00, 1'b0, 32'd0);
  @(posedge clk);
  compare_value("operand_ready_o[1]", operand_ready[1], 1'b1);
  compare_value("operand_data_o[1]", operand_data[1], 32'hcafe_0001);
  compare_value("operand_ready_o[0]", operand_ready[0], 1'b0);
  drain_rob();
endtask

task automatic in_order_commit();
  rid_t older;
  rid_t younger;
  int   base;
  int   dual;
  dispatch_two(older, younger);
  base = commit_count;
  dual = dual_count;
  complete(younger, 32'h1111_2222, 2'b00, 1'b0, 32'd0);
  repeat (3) begin
    @(posedge clk);
    compare_value("commit_valid_o", commit_valid, 2'b00);
  end
  complete(older, 32'h3333_4444, 2'b00, 1'b0, 32'd0);
  wait_commits(base + 2);
  expect_true(dual_count == dual + 1, "older and younger entries did not retire together");
endtask

task automatic flush_on_exception();
  rid_t id0;
  rid_t id1;
  rid_t id2;
  rid_t id3;
  int   base;
  int   fl;
  dispatch_two(id0, id1);
  dispatch_two(id2, id3);
  base = commit_count;
  fl   = flush_count;
  complete_two(id1, 32'h2222_0001, id2, 32'h2222_0002);
  complete(id0, 32'h0bad_0000, 2'b01, 1'b0, 32'd0);
  wait_flushes(fl + 1);
  repeat (4) @(negedge clk);
  expect_true(commit_count == base + 1, "younger entries committed past an exception");
endtask

task automatic flush_on_jump();
  rid_t id0;
  rid_t id1;
  int   base;
  int   fl;
  dispatch_two(id0, id1);
  base = commit_count;
  fl   = flush_count;
  complete(id1, 32'h4444_0001, 2'b00, 1'b0, 32'd0);
  complete(id0, 32'h4444_0000, 2'b00, 1'b1, 32'h1c00_4400);
  wait_flushes(fl + 1);
  repeat (4) @(negedge clk);
  expect_true(commit_count == base + 1, "younger entry committed past a taken jump");
endtask

task automatic back_pressure();
  rid_t a;
  rid_t b;
  int   base;
  for (int i = 0; i < 7; i++) begin
    dispatch_two(a, b);
  end
  dispatch_one(a);
  base = commit_count;
  @(posedge clk);
  compare_value("dispatch_ready_o", dispatch_ready, 1'b0);
  complete_two(model_q[0], 32'h7000_0000, model_q[1], 32'h7000_0001);
  wait_commits(base + 2);
  @(posedge clk);
  compare_value("dispatch_ready_o", dispatch_ready, 1'b1);
  drain_rob();
endtask

// the second round wraps the ids past the end of the ROB
task automatic random_completion();
  rid_t ids[$];
  rid_t a;
  rid_t b;
  rid_t t;
  int   j;
  int   base;
  for (int round = 0; round < 2; round++) begin
    for (int i = 0; i < 7; i++) begin
      dispatch_two(a, b);
    end
    ids  = model_q;
    base = commit_count;
    for (int i = ids.size() - 1; i > 0; i--) begin
      j      = $unsigned($random(seed)) % (i + 1);
      t      = ids[i];
      ids[i] = ids[j];
      ids[j] = t;
    end
    for (int i = 0; i + 1 < ids.size(); i += 2) begin
      complete_two(ids[i], $random(seed), ids[i + 1], $random(seed));
    end
    wait_empty();
    expect_true(commit_count == base + 14, "random round did not commit every entry");
  end
endtask

// ==== tb_wired_rob.sv ====
`timescale 1ns/100ps

module tb_wired_rob;
  import wired_pkg::*;

  localparam int ROB_LEN = 4;
  localparam int DEPTH   = 1 << ROB_LEN;
  // cycle budget per test, in run order
  localparam int RUN_CYCLES = 10 + 40 + 40 + 50 + 40 + 120 + 160;

  typedef logic [ROB_LEN-1:0] rid_t;

  logic            clk;
  logic            rst_n;
  logic      [1:0] dispatch_valid;
  arch_rid_t [1:0] dispatch_wreg;
  logic      [1:0] dispatch_we;
  word_t     [1:0] dispatch_pc;
  logic            dispatch_ready;
  rid_t      [1:0] dispatch_rob_id;
  rid_t      [3:0] src_rob_id;
  logic      [3:0] operand_ready;
  word_t     [3:0] operand_data;
  logic      [1:0] cdb_valid;
  rid_t      [1:0] cdb_wid;
  word_t     [1:0] cdb_wdata;
  excp_t     [1:0] cdb_excp;
  logic      [1:0] cdb_need_jump;
  word_t     [1:0] cdb_target;
  logic      [1:0] commit_valid;
  arch_rid_t [1:0] commit_wreg;
  word_t     [1:0] commit_wdata;
  word_t     [1:0] commit_pc;
  logic            commit_excp;
  logic            flush;
  word_t           redirect_pc;

  int errors;
  int seed;

  `include "tb_wired_rob_tasks.svh"

  wired_rob_top #(.ROB_LEN(ROB_LEN)) dut0 (
    .clk              (clk),
    .rst_n_i          (rst_n),
    .dispatch_valid_i (dispatch_valid),
    .dispatch_wreg_i  (dispatch_wreg),
    .dispatch_we_i    (dispatch_we),
    .dispatch_pc_i    (dispatch_pc),
    .dispatch_ready_o (dispatch_ready),
    .dispatch_rob_id_o(dispatch_rob_id),
    .src_rob_id_i     (src_rob_id),
    .operand_ready_o  (operand_ready),
    .operand_data_o   (operand_data),
    .cdb_valid_i      (cdb_valid),
    .cdb_wid_i        (cdb_wid),
    .cdb_wdata_i      (cdb_wdata),
    .cdb_excp_i       (cdb_excp),
    .cdb_need_jump_i  (cdb_need_jump),
    .cdb_target_i     (cdb_target),
    .commit_valid_o   (commit_valid),
    .commit_wreg_o    (commit_wreg),
    .commit_wdata_o   (commit_wdata),
    .commit_pc_o      (commit_pc),
    .commit_excp_o    (commit_excp),
    .flush_o          (flush),
    .redirect_pc_o    (redirect_pc)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // reference model follows every active edge
  always @(posedge clk) begin
    if (rst_n) begin
      observe_edge();
    end
  end

  initial begin
    #((RUN_CYCLES + 200) * 20);
    $display("watchdog expired at time %0d ns", $time);
    $display("errors: %0d  commits: %0d  flushes: %0d", errors, commit_count, flush_count);
    $display("Test failed");
    $finish;
  end

  initial begin
    errors       = 0;
    seed         = 72826;
    commit_count = 0;
    flush_count  = 0;
    dual_count   = 0;
    tail_m       = '0;
    next_pc      = 32'h1c00_0000;
    rst_n        = 1'b0;
    clear_inputs();
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    after_reset();
    forwarding_readiness();
    in_order_commit();
    flush_on_exception();
    flush_on_jump();
    back_pressure();
    random_completion();
    repeat (4) @(negedge clk);
    $display("errors: %0d  commits: %0d  flushes: %0d", errors, commit_count, flush_count);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== wired_pkg.sv ====
package wired_pkg;

  // basic datapath words
  typedef logic [31:0] word_t;
  typedef logic [1:0]  excp_t;
  typedef logic [4:0]  arch_rid_t;

  // fetch redirect target on any exception
  localparam word_t EXCP_VECTOR = 32'h1c00_8000;

  // static part of an entry, written once at dispatch
  typedef struct packed {
    arch_rid_t wreg;
    logic      we;
    word_t     pc;
  } rob_static_t;

  // dynamic part of an entry, filled in by the result bus
  typedef struct packed {
    excp_t excp;
    logic  need_jump;
    word_t target;
  } rob_dynamic_t;

  // an entry that stops the in-order stream and redirects fetch
  function automatic logic need_flush(rob_dynamic_t d);
    return (d.excp != '0) || d.need_jump;
  endfunction

endpackage

// ==== wired_registers_file_banked.sv ====
`timescale 1ns/100ps

module wired_registers_file_banked #(
  parameter int DATA_WIDTH   = 32,
  parameter int DEPTH        = 16,
  parameter int R_PORT_COUNT = 2,
  parameter int W_PORT_COUNT = 2
) (
  input  logic                                       clk,
  input  logic                                       rst_n_i,
  input  logic [R_PORT_COUNT-1:0][$clog2(DEPTH)-1:0] raddr_i,
  output logic [R_PORT_COUNT-1:0][DATA_WIDTH-1:0]    rdata_o,
  input  logic [W_PORT_COUNT-1:0][$clog2(DEPTH)-1:0] waddr_i,
  input  logic [W_PORT_COUNT-1:0]                    we_i,
  input  logic [W_PORT_COUNT-1:0][DATA_WIDTH-1:0]    wdata_i
);

  logic [DEPTH-1:0][DATA_WIDTH-1:0] regs_q;

  // later ports overwrite earlier ones on the same address
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      regs_q <= '0;
    end else begin
      for (int w = 0; w < W_PORT_COUNT; w++) begin
        if (we_i[w]) begin
          regs_q[waddr_i[w]] <= wdata_i[w];
        end
      end
    end
  end

  // plain read muxes, no bypass from same-cycle writes
  for (genvar r = 0; r < R_PORT_COUNT; r++) begin : g_rd
    assign rdata_o[r] = regs_q[raddr_i[r]];
  end

  // callers keep write addresses apart within a cycle
  for (genvar i = 0; i < W_PORT_COUNT; i++) begin : g_wchk_i
    for (genvar j = i + 1; j < W_PORT_COUNT; j++) begin : g_wchk_j
      a_no_waddr_clash : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !(we_i[i] && we_i[j] && (waddr_i[i] == waddr_i[j]))
      ) else $error("write ports %0d and %0d hit the same address", i, j);
    end
  end

endmodule

// ==== wired_rob.sv ====
`timescale 1ns/100ps

module wired_rob #(
  parameter int ROB_LEN = 4
) (
  input  logic                                clk,
  input  logic                                rst_n_i,
  input  logic                  [1:0]              p_valid_i,
  input  logic                  [1:0][ROB_LEN-1:0] p_wrrid_i,
  input  wired_pkg::rob_static_t [1:0]             p_winfo_i,
  input  logic                  [3:0][ROB_LEN-1:0] p_rrrid_i,
  output logic                  [3:0]              p_rob_valid_o,
  output wired_pkg::word_t      [3:0]              p_rrdata_o,
  output logic                  [ROB_LEN:0]        count_o,
  wired_cdb_if.sink                                cdb,
  wired_commit_if.rob                              cmt,
  input  logic                                     flush_i
);
  import wired_pkg::*;

  localparam int DEPTH = 1 << ROB_LEN;

  // static table, dispatch writes, commit reads
  wired_registers_file_banked #(
    .DATA_WIDTH   ($bits(rob_static_t)),
    .DEPTH        (DEPTH),
    .R_PORT_COUNT (2),
    .W_PORT_COUNT (2)
  ) rob_static (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .raddr_i (cmt.rid),
    .rdata_o (cmt.s_info),
    .waddr_i (p_wrrid_i),
    .we_i    (p_valid_i),
    .wdata_i (p_winfo_i)
  );

  // data table, also read by dispatch for forwarding
  word_t [5:0] data_rd;

  wired_registers_file_banked #(
    .DATA_WIDTH   ($bits(word_t)),
    .DEPTH        (DEPTH),
    .R_PORT_COUNT (6),
    .W_PORT_COUNT (2)
  ) rob_data (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .raddr_i ({cmt.rid, p_rrrid_i}),
    .rdata_o (data_rd),
    .waddr_i (cdb.wid),
    .we_i    (cdb.valid),
    .wdata_i (cdb.wdata)
  );

  assign p_rrdata_o = data_rd[3:0];
  assign cmt.wdata  = data_rd[5:4];

  // dynamic table
  rob_dynamic_t [1:0] cdb_dyn;

  for (genvar k = 0; k < 2; k++) begin : g_cdb_dyn
    assign cdb_dyn[k].excp      = cdb.excp[k];
    assign cdb_dyn[k].need_jump = cdb.need_jump[k];
    assign cdb_dyn[k].target    = cdb.target[k];
  end

  wired_registers_file_banked #(
    .DATA_WIDTH   ($bits(rob_dynamic_t)),
    .DEPTH        (DEPTH),
    .R_PORT_COUNT (2),
    .W_PORT_COUNT (2)
  ) rob_dynamic (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .raddr_i (cmt.rid),
    .rdata_o (cmt.d_info),
    .waddr_i (cdb.wid),
    .we_i    (cdb.valid),
    .wdata_i (cdb_dyn)
  );

  // toggle pair, ready when valid_p and valid_c differ
  // read order: commit slots, operands, then the writer's own lookup
  logic [7:0] vp_rd;
  logic [7:0] vc_rd;

  wired_registers_file_banked #(
    .DATA_WIDTH   (1),
    .DEPTH        (DEPTH),
    .R_PORT_COUNT (8),
    .W_PORT_COUNT (2)
  ) rob_valid_p (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .raddr_i ({cmt.rid, p_rrrid_i, cdb.wid}),
    .rdata_o (vp_rd),
    .waddr_i (p_wrrid_i),
    .we_i    (p_valid_i),
    .wdata_i (vc_rd[1:0])
  );

  wired_registers_file_banked #(
    .DATA_WIDTH   (1),
    .DEPTH        (DEPTH),
    .R_PORT_COUNT (8),
    .W_PORT_COUNT (2)
  ) rob_valid_c (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .raddr_i ({cmt.rid, p_rrrid_i, p_wrrid_i}),
    .rdata_o (vc_rd),
    .waddr_i (cdb.wid),
    .we_i    (cdb.valid),
    .wdata_i (~vp_rd[1:0])
  );

  assign p_rob_valid_o = vp_rd[5:2] ^ vc_rd[5:2];
  assign cmt.ready     = vp_rd[7:6] ^ vc_rd[7:6];

  // occupancy, dispatches in and retires out
  logic [ROB_LEN:0] count_q;
  logic [ROB_LEN:0] count_d;

  always_comb begin
    count_d = count_q;
    for (int k = 0; k < 2; k++) begin
      count_d = count_d + {{ROB_LEN{1'b0}}, p_valid_i[k]} - {{ROB_LEN{1'b0}}, cmt.retire[k]};
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else if (flush_i) begin
      count_q <= '0;
    end else begin
      count_q <= count_d;
    end
  end

  assign count_o        = count_q;
  assign cmt.present[0] = (count_q != '0);
  assign cmt.present[1] = (count_q > 1);

  a_retire_present : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    (cmt.retire[0] -> count_q != '0) && (cmt.retire[1] -> count_q > 1)
  ) else $error("retire of an entry that was never allocated");

  // the commit flush must reach the counter through the top
  a_flush_empties : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    cmt.flush |=> (count_q == '0)
  ) else $error("ROB not empty after flush");

endmodule

// ==== wired_rob_commit.sv ====
`timescale 1ns/100ps

module wired_rob_commit #(
  parameter int ROB_LEN = 4
) (
  input  logic                       clk,
  input  logic                       rst_n_i,
  wired_commit_if.commit             cmt,
  output logic                 [1:0] commit_valid_o,
  output wired_pkg::arch_rid_t [1:0] commit_wreg_o,
  output wired_pkg::word_t     [1:0] commit_wdata_o,
  output wired_pkg::word_t     [1:0] commit_pc_o,
  output logic                       commit_excp_o,
  output logic                       flush_o,
  output wired_pkg::word_t           redirect_pc_o
);
  import wired_pkg::*;

  logic [ROB_LEN-1:0] head_q;
  logic [ROB_LEN-1:0] head_d;
  logic [1:0]         retire;
  logic               slot0_stop;
  logic               slot0_excp;
  logic               flush;

  assign cmt.rid[0] = head_q;
  assign cmt.rid[1] = head_q + 1'b1;

  assign slot0_stop = need_flush(cmt.d_info[0]);
  assign slot0_excp = (cmt.d_info[0].excp != '0);

  // in order, and nothing passes a redirecting entry
  assign retire[0] = cmt.present[0] & cmt.ready[0];
  assign retire[1] = retire[0] & ~slot0_stop & cmt.present[1] & cmt.ready[1];
  assign flush     = retire[0] & slot0_stop;

  assign cmt.retire     = retire;
  assign cmt.flush      = flush;
  assign commit_valid_o = retire;
  assign flush_o        = flush;
  assign commit_excp_o  = retire[0] & slot0_excp;

  // exception beats a jump on the same entry
  assign redirect_pc_o = slot0_excp ? EXCP_VECTOR : cmt.d_info[0].target;

  for (genvar k = 0; k < 2; k++) begin : g_slot
    assign commit_wreg_o[k]  = (retire[k] && cmt.s_info[k].we) ? cmt.s_info[k].wreg : '0;
    assign commit_wdata_o[k] = (retire[k] && cmt.s_info[k].we) ? cmt.wdata[k] : '0;
    assign commit_pc_o[k]    = cmt.s_info[k].pc;
  end

  always_comb begin
    head_d = head_q;
    for (int k = 0; k < 2; k++) begin
      head_d = head_d + {{(ROB_LEN - 1){1'b0}}, retire[k]};
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      head_q <= '0;
    end else if (flush) begin
      head_q <= '0;
    end else begin
      head_q <= head_d;
    end
  end

  a_slot1_after_slot0 : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    retire[1] |-> retire[0]
  ) else $error("slot 1 retired without slot 0");

  // flushed ROB has nothing left to hand over
  a_quiet_after_flush : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    flush |=> (retire == '0)
  ) else $error("commit right after flush");

endmodule

// ==== wired_rob_dispatch.sv ====
`timescale 1ns/100ps

module wired_rob_dispatch #(
  parameter int ROB_LEN = 4
) (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  logic [1:0]              dispatch_valid_i,
  input  logic [ROB_LEN:0]        count_i,
  input  logic                    flush_i,
  output logic                    dispatch_ready_o,
  output logic [1:0]              p_valid_o,
  output logic [1:0][ROB_LEN-1:0] p_wrrid_o
);

  localparam int DEPTH = 1 << ROB_LEN;

  logic [ROB_LEN-1:0] tail_q;
  logic [ROB_LEN-1:0] tail_d;

  // always room for a full pair when ready is up
  assign dispatch_ready_o = (count_i <= (ROB_LEN + 1)'(DEPTH - 2));
  assign p_valid_o        = dispatch_valid_i & {2{dispatch_ready_o}};

  // lane 1 takes tail+1 only behind a valid lane 0
  assign p_wrrid_o[0] = tail_q;
  assign p_wrrid_o[1] = dispatch_valid_i[0] ? tail_q + 1'b1 : tail_q;

  always_comb begin
    tail_d = tail_q;
    for (int k = 0; k < 2; k++) begin
      tail_d = tail_d + {{(ROB_LEN - 1){1'b0}}, p_valid_o[k]};
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tail_q <= '0;
    end else if (flush_i) begin
      tail_q <= '0;
    end else begin
      tail_q <= tail_d;
    end
  end

  a_no_dispatch_when_full : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    !dispatch_ready_o |-> (dispatch_valid_i == '0)
  ) else $error("dispatch while ROB is not ready");

endmodule

// ==== wired_rob_if.sv ====
`timescale 1ns/100ps

// two result bus lanes toward the ROB
interface wired_cdb_if #(
  parameter int ROB_LEN = 4
);
  import wired_pkg::*;

  logic  [1:0]              valid;
  logic  [1:0][ROB_LEN-1:0] wid;
  word_t [1:0]              wdata;
  excp_t [1:0]              excp;
  logic  [1:0]              need_jump;
  word_t [1:0]              target;

  modport source (output valid, wid, wdata, excp, need_jump, target);
  modport sink   (input  valid, wid, wdata, excp, need_jump, target);
endinterface

// head entry read and retire handshake between ROB and commit
interface wired_commit_if #(
  parameter int ROB_LEN = 4
);
  import wired_pkg::*;

  logic         [1:0][ROB_LEN-1:0] rid;
  logic         [1:0]              present;
  logic         [1:0]              ready;
  rob_static_t  [1:0]              s_info;
  rob_dynamic_t [1:0]              d_info;
  word_t        [1:0]              wdata;
  logic         [1:0]              retire;
  logic                            flush;

  modport rob    (input rid, retire, flush, output present, ready, s_info, d_info, wdata);
  modport commit (output rid, retire, flush, input present, ready, s_info, d_info, wdata);
endinterface

// ==== wired_rob_top.sv ====
`timescale 1ns/100ps

module wired_rob_top #(
  parameter int ROB_LEN = 4
) (
  input  logic                          clk,
  input  logic                          rst_n_i,
  input  logic                 [1:0]              dispatch_valid_i,
  input  wired_pkg::arch_rid_t [1:0]              dispatch_wreg_i,
  input  logic                 [1:0]              dispatch_we_i,
  input  wired_pkg::word_t     [1:0]              dispatch_pc_i,
  output logic                                    dispatch_ready_o,
  output logic                 [1:0][ROB_LEN-1:0] dispatch_rob_id_o,
  input  logic                 [3:0][ROB_LEN-1:0] src_rob_id_i,
  output logic                 [3:0]              operand_ready_o,
  output wired_pkg::word_t     [3:0]              operand_data_o,
  input  logic                 [1:0]              cdb_valid_i,
  input  logic                 [1:0][ROB_LEN-1:0] cdb_wid_i,
  input  wired_pkg::word_t     [1:0]              cdb_wdata_i,
  input  wired_pkg::excp_t     [1:0]              cdb_excp_i,
  input  logic                 [1:0]              cdb_need_jump_i,
  input  wired_pkg::word_t     [1:0]              cdb_target_i,
  output logic                 [1:0]              commit_valid_o,
  output wired_pkg::arch_rid_t [1:0]              commit_wreg_o,
  output wired_pkg::word_t     [1:0]              commit_wdata_o,
  output wired_pkg::word_t     [1:0]              commit_pc_o,
  output logic                                    commit_excp_o,
  output logic                                    flush_o,
  output wired_pkg::word_t                        redirect_pc_o
);
  import wired_pkg::*;

  wired_cdb_if    #(.ROB_LEN(ROB_LEN)) cdb_bus ();
  wired_commit_if #(.ROB_LEN(ROB_LEN)) cmt_bus ();

  logic        [1:0]              p_valid;
  logic        [1:0][ROB_LEN-1:0] p_wrrid;
  rob_static_t [1:0]              p_winfo;
  logic        [ROB_LEN:0]        count;

  assign cdb_bus.valid     = cdb_valid_i;
  assign cdb_bus.wid       = cdb_wid_i;
  assign cdb_bus.wdata     = cdb_wdata_i;
  assign cdb_bus.excp      = cdb_excp_i;
  assign cdb_bus.need_jump = cdb_need_jump_i;
  assign cdb_bus.target    = cdb_target_i;

  for (genvar k = 0; k < 2; k++) begin : g_winfo
    assign p_winfo[k].wreg = dispatch_wreg_i[k];
    assign p_winfo[k].we   = dispatch_we_i[k];
    assign p_winfo[k].pc   = dispatch_pc_i[k];
  end

  assign dispatch_rob_id_o = p_wrrid;

  wired_rob_dispatch #(.ROB_LEN(ROB_LEN)) u_dispatch (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .dispatch_valid_i (dispatch_valid_i),
    .count_i          (count),
    .flush_i          (flush_o),
    .dispatch_ready_o (dispatch_ready_o),
    .p_valid_o        (p_valid),
    .p_wrrid_o        (p_wrrid)
  );

  wired_rob #(.ROB_LEN(ROB_LEN)) u_rob (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .p_valid_i     (p_valid),
    .p_wrrid_i     (p_wrrid),
    .p_winfo_i     (p_winfo),
    .p_rrrid_i     (src_rob_id_i),
    .p_rob_valid_o (operand_ready_o),
    .p_rrdata_o    (operand_data_o),
    .count_o       (count),
    .cdb           (cdb_bus.sink),
    .cmt           (cmt_bus.rob),
    .flush_i       (flush_o)
  );

  wired_rob_commit #(.ROB_LEN(ROB_LEN)) u_commit (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .cmt            (cmt_bus.commit),
    .commit_valid_o (commit_valid_o),
    .commit_wreg_o  (commit_wreg_o),
    .commit_wdata_o (commit_wdata_o),
    .commit_pc_o    (commit_pc_o),
    .commit_excp_o  (commit_excp_o),
    .flush_o        (flush_o),
    .redirect_pc_o  (redirect_pc_o)
  );

endmodule
